// File: bench/adc_model.sv
// behavioral serial ADC for the testbench
// latches a sample when cs_n falls and shifts it out MSB first on sclk falls
module adc_model #(
  parameter int drive_dly = 1
) (
  input  logic             cs_n,
  input  logic             sclk,
  input  acq_pkg::sample_t next_sample,
  output logic             sdata
);

  acq_pkg::sample_t shift_q;
  logic             cs_prev;

  initial begin
    sdata   = 1'b0;
    shift_q = '0;
    cs_prev = 1'b1;
  end

  // one process owns the shift register and sdata
  always @(negedge cs_n or negedge sclk) begin
    if (cs_n === 1'b0) begin
      if (cs_prev) begin
        // frame opens, MSB goes out right away
        shift_q = next_sample;
      end else begin
        shift_q = {shift_q[acq_pkg::sample_w-2:0], 1'b0};
      end
      #drive_dly;
      sdata = shift_q[acq_pkg::sample_w-1];
    end
    // sclk falls after the frame closes are ignored
    cs_prev = (cs_n !== 1'b0);
  end

endmodule

// File: bench/tb_acq_top.sv
// testbench for the two-channel acquisition front end
// table frames through two ADC models, host reads checked against a boxcar model
module tb_acq_top;

  localparam int sclk_div       = 2;
  localparam int alarm_limit    = 1000;
  localparam int n_rows         = 12;
  localparam int frame_cycles   = 32 * sclk_div + acq_pkg::gap_cycles;
  localparam int timeout_cycles = n_rows * frame_cycles + 200;
  localparam int drive_dly      = 10;

  // one frame of stimulus and its expected alarm
  typedef struct packed {
    acq_pkg::sample_t raw_a;
    acq_pkg::sample_t raw_b;
    logic             alarm;
  } row_t;

  logic             clk_sys;
  logic             arst_n;
  logic             sdata_a;
  logic             sdata_b;
  logic             cs_a_n;
  logic             sclk_a;
  logic             cs_b_n;
  logic             sclk_b;
  logic             rd_req;
  logic             rd_ack;
  acq_pkg::result_t rd_data;
  logic             irq_n;
  acq_pkg::sample_t next_a;
  acq_pkg::sample_t next_b;

  int   err_cnt;
  int   fail_cnt;
  int   cycle_cnt;
  int   exp_a [n_rows+1];
  int   exp_b [n_rows+1];
  // alarm of the frame that follows the table
  logic late_alarm;

  // b stays at 30000, a walks the difference around the 1000 limit
  row_t rows [n_rows] = '{
    '{raw_a: 16'd30000, raw_b: 16'd30000, alarm: 1'b0},
    '{raw_a: 16'd30000, raw_b: 16'd30000, alarm: 1'b0},
    '{raw_a: 16'd30000, raw_b: 16'd30000, alarm: 1'b0},
    '{raw_a: 16'd33996, raw_b: 16'd30000, alarm: 1'b0},
    '{raw_a: 16'd30008, raw_b: 16'd30000, alarm: 1'b1},
    '{raw_a: 16'd25996, raw_b: 16'd30000, alarm: 1'b0},
    '{raw_a: 16'd22000, raw_b: 16'd30000, alarm: 1'b1},
    '{raw_a: 16'd38000, raw_b: 16'd30000, alarm: 1'b0},
    '{raw_a: 16'd30000, raw_b: 16'd30000, alarm: 1'b1},
    '{raw_a: 16'd30000, raw_b: 16'd30000, alarm: 1'b0},
    // spare rows, filled from $urandom
    '{raw_a: 16'd0, raw_b: 16'd0, alarm: 1'b0},
    '{raw_a: 16'd0, raw_b: 16'd0, alarm: 1'b0}
  };

  acq_top i_acq_top (
    .clk_sys(clk_sys),
    .arst_n(arst_n),
    .sdata_a(sdata_a),
    .sdata_b(sdata_b),
    .cs_a_n(cs_a_n),
    .sclk_a(sclk_a),
    .cs_b_n(cs_b_n),
    .sclk_b(sclk_b),
    .rd_req(rd_req),
    .rd_ack(rd_ack),
    .rd_data(rd_data),
    .irq_n(irq_n)
  );

  adc_model adc_a (.cs_n(cs_a_n), .sclk(sclk_a), .next_sample(next_a), .sdata(sdata_a));
  adc_model adc_b (.cs_n(cs_b_n), .sclk(sclk_b), .next_sample(next_b), .sdata(sdata_b));

  initial begin
    clk_sys = 1'b0;
    forever #50 clk_sys = ~clk_sys;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk_sys);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
    $display("STATUS: FAIL");
    $finish;
  end

  // --------------------
  // helpers
  // --------------------
  task automatic next_cycle();
    @(posedge clk_sys);
    #drive_dly;
  endtask

  task automatic compare_field(input string what, input int got, input int exp);
    assert (got == exp) else begin
      $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      err_cnt = err_cnt + 1;
    end
  endtask

  task automatic check_held(input acq_pkg::result_t snap);
    assert (rd_data == snap) else begin
      $display("Error at %0t: rd_data changed during ack, %h instead of %h",
               $time, rd_data, snap);
      err_cnt = err_cnt + 1;
    end
  endtask

  // four-deep boxcar, history zero after reset
  // one extra frame repeats the last row, the ADC model keeps that sample
  task automatic build_expected();
    int hist_a [4];
    int hist_b [4];
    int d;
    int src;
    for (int k = 0; k < 4; k++) begin
      hist_a[k] = 0;
      hist_b[k] = 0;
    end
    for (int i = 0; i <= n_rows; i++) begin
      src = (i < n_rows) ? i : n_rows - 1;
      for (int k = 3; k > 0; k--) begin
        hist_a[k] = hist_a[k-1];
        hist_b[k] = hist_b[k-1];
      end
      hist_a[0] = int'(rows[src].raw_a);
      hist_b[0] = int'(rows[src].raw_b);
      exp_a[i]  = (hist_a[0] + hist_a[1] + hist_a[2] + hist_a[3]) >> 2;
      exp_b[i]  = (hist_b[0] + hist_b[1] + hist_b[2] + hist_b[3]) >> 2;
      d = exp_a[i] - exp_b[i];
      // random rows and the extra frame get their alarm from the model
      if (i == n_rows) begin
        late_alarm = (((d < 0) ? -d : d) > alarm_limit);
      end else if (i >= 10) begin
        rows[i].alarm = (((d < 0) ? -d : d) > alarm_limit);
      end
    end
  endtask

  // --------------------
  // one frame and its host read
  // --------------------
  task automatic run_frame(input int idx);
    acq_pkg::result_t snap;
    int errs_at_start;
    logic exp_irq_n;
    errs_at_start = err_cnt;
    exp_irq_n = 1'b1;
    while (cs_a_n !== 1'b0) next_cycle();
    while (cs_a_n !== 1'b1) next_cycle();
    compare_field("cs_b_n at frame end", int'(cs_b_n), 1);
    // model latches these at the next cs_n fall
    if (idx + 1 < n_rows) begin
      next_a = rows[idx+1].raw_a;
      next_b = rows[idx+1].raw_b;
    end
    repeat (3) next_cycle();
    compare_field("irq_n before read", int'(irq_n), int'(!rows[idx].alarm));
    compare_field("rd_ack before read", int'(rd_ack), 0);
    rd_req = 1'b1;
    while (rd_ack !== 1'b1) next_cycle();
    snap = rd_data;
    compare_field("rd_data.ch_a", int'(rd_data.ch_a), exp_a[idx]);
    compare_field("rd_data.ch_b", int'(rd_data.ch_b), exp_b[idx]);
    compare_field("rd_data.diff", int'($signed(rd_data.diff)), exp_a[idx] - exp_b[idx]);
    compare_field("rd_data.alarm", int'(rd_data.alarm), int'(rows[idx].alarm));
    repeat (2) begin
      next_cycle();
      compare_field("rd_ack while rd_req high", int'(rd_ack), 1);
      check_held(snap);
    end
    // last read stays open until the next frame's record has landed
    if (idx == n_rows - 1) begin
      while (cs_a_n !== 1'b0) begin
        check_held(snap);
        next_cycle();
      end
      while (cs_a_n !== 1'b1) begin
        check_held(snap);
        next_cycle();
      end
      repeat (3) begin
        next_cycle();
        check_held(snap);
      end
      compare_field("rd_ack across a new record", int'(rd_ack), 1);
      exp_irq_n = !late_alarm;
    end
    rd_req = 1'b0;
    while (rd_ack !== 1'b0) begin
      check_held(snap);
      next_cycle();
    end
    compare_field("irq_n after read", int'(irq_n), int'(exp_irq_n));
    if (err_cnt != errs_at_start) begin
      fail_cnt = fail_cnt + 1;
    end
    $display("frame %0d: raw a=%0d b=%0d, avg a=%0d b=%0d, alarm %0d, %s",
             idx, rows[idx].raw_a, rows[idx].raw_b, exp_a[idx], exp_b[idx],
             rows[idx].alarm, (err_cnt == errs_at_start) ? "ok" : "FAILED");
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin : main
    int i;
    int errs_before;
    err_cnt  = 0;
    fail_cnt = 0;
    arst_n   = 1'b0;
    rd_req   = 1'b0;
    void'($urandom(32'h3f5c8a18));
    for (i = 10; i < n_rows; i++) begin
      rows[i].raw_a = 16'($urandom());
      rows[i].raw_b = 16'($urandom());
    end
    build_expected();
    next_a = rows[0].raw_a;
    next_b = rows[0].raw_b;

    repeat (2) @(posedge clk_sys);
    #drive_dly;
    arst_n = 1'b1;

    // idle state before the first frame
    errs_before = err_cnt;
    compare_field("cs_a_n after reset", int'(cs_a_n), 1);
    compare_field("cs_b_n after reset", int'(cs_b_n), 1);
    compare_field("sclk_a after reset", int'(sclk_a), 0);
    compare_field("sclk_b after reset", int'(sclk_b), 0);
    compare_field("rd_ack after reset", int'(rd_ack), 0);
    compare_field("irq_n after reset", int'(irq_n), 1);
    if (err_cnt != errs_before) begin
      fail_cnt = fail_cnt + 1;
    end
    $display("reset state: %s", (err_cnt == errs_before) ? "ok" : "FAILED");

    for (i = 0; i < n_rows; i++) begin
      run_frame(i);
    end

    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             n_rows + 1, n_rows + 1 - fail_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: hdl/acq_pkg.sv
// shared types for the two-channel acquisition front end
// sample widths, stream and record structs, FSM state encodings
package acq_pkg;

  // --------------------
  // widths and timing
  // --------------------

  // raw ADC sample width
  localparam int sample_w = 16;

  // clk_sys cycles with cs_n high before a frame starts
  localparam int gap_cycles = 8;

  // unsigned raw or smoothed sample
  typedef logic [sample_w-1:0] sample_t;

  // signed channel difference, one bit wider than a sample
  typedef logic signed [sample_w:0] diff_t;

  // --------------------
  // stream structs
  // --------------------

  // one sample between capture, smoothing and combine
  typedef struct packed {
    sample_t sample;
    logic    vld;
  } chan_data_t;

  // combined record as seen by the host
  typedef struct packed {
    sample_t ch_a;
    sample_t ch_b;
    diff_t   diff;
    logic    alarm;
  } result_t;

  // --------------------
  // FSM states
  // --------------------

  // serial capture
  typedef enum logic [1:0] {
    cap_gap,
    cap_shift,
    cap_done
  } cap_state_t;

  // four-phase read handshake
  typedef enum logic {
    rd_idle,
    rd_ack_hi
  } rd_state_t;

endpackage

// File: hdl/acq_top.sv
// two-channel acquisition front end
// per-channel capture and smoothing, then combine and host read port
module acq_top #(
  parameter int               sclk_div    = 2,
  parameter int               avg_log2    = 2,
  parameter acq_pkg::sample_t alarm_limit = 16'd1000
) (
  input  logic             clk_sys,
  input  logic             arst_n,
  input  logic             sdata_a,
  input  logic             sdata_b,
  output logic             cs_a_n,
  output logic             sclk_a,
  output logic             cs_b_n,
  output logic             sclk_b,
  input  logic             rd_req,
  output logic             rd_ack,
  output acq_pkg::result_t rd_data,
  output logic             irq_n
);

  acq_pkg::chan_data_t ad_a;
  acq_pkg::chan_data_t ad_b;
  acq_pkg::chan_data_t sm_a;
  acq_pkg::chan_data_t sm_b;
  acq_pkg::result_t    res;
  logic                res_vld;

  // --------------------
  // channel a
  // --------------------
  ad_capture #(.sclk_div(sclk_div)) ad_a_top (
    .clk_sys(clk_sys),
    .arst_n(arst_n),
    .sdata(sdata_a),
    .cs_n(cs_a_n),
    .sclk(sclk_a),
    .smp(ad_a)
  );

  dsp_smooth #(.avg_log2(avg_log2)) dsp_a_top (
    .clk_sys(clk_sys),
    .arst_n(arst_n),
    .smp_in(ad_a),
    .smp_out(sm_a)
  );

  // --------------------
  // channel b
  // --------------------
  ad_capture #(.sclk_div(sclk_div)) ad_b_top (
    .clk_sys(clk_sys),
    .arst_n(arst_n),
    .sdata(sdata_b),
    .cs_n(cs_b_n),
    .sclk(sclk_b),
    .smp(ad_b)
  );

  dsp_smooth #(.avg_log2(avg_log2)) dsp_b_top (
    .clk_sys(clk_sys),
    .arst_n(arst_n),
    .smp_in(ad_b),
    .smp_out(sm_b)
  );

  // --------------------
  // combine and host side
  // --------------------
  app_combine #(.alarm_limit(alarm_limit)) u_app_combine (
    .clk_sys(clk_sys),
    .arst_n(arst_n),
    .a(sm_a),
    .b(sm_b),
    .res(res),
    .res_vld(res_vld)
  );

  host_port u_host_port (
    .clk_sys(clk_sys),
    .arst_n(arst_n),
    .res(res),
    .res_vld(res_vld),
    .rd_req(rd_req),
    .rd_ack(rd_ack),
    .rd_data(rd_data),
    .irq_n(irq_n)
  );

endmodule

// File: hdl/ad_capture.sv
// serial ADC capture for one channel
// generates cs_n and sclk, shifts in one 16-bit sample per frame MSB first
module ad_capture #(
  parameter int sclk_div = 2
) (
  input  logic                clk_sys,
  input  logic                arst_n,
  input  logic                sdata,
  output logic                cs_n,
  output logic                sclk,
  output acq_pkg::chan_data_t smp
);

  // one counter times both the gap and the sclk half periods
  localparam int cnt_max = (sclk_div > acq_pkg::gap_cycles) ? sclk_div : acq_pkg::gap_cycles;
  localparam int cnt_w   = $clog2(cnt_max + 1);
  localparam int bit_w   = $clog2(acq_pkg::sample_w);

  acq_pkg::cap_state_t state_q;
  logic [cnt_w-1:0]    cnt_q;
  logic [bit_w-1:0]    bit_q;
  logic                cs_n_q;
  logic                sclk_q;
  logic                vld_q;
  acq_pkg::sample_t    shift_q;
  acq_pkg::sample_t    data_q;
  logic                half_end;
  logic                gap_end;
  logic                rise;
  logic                last_bit;
  acq_pkg::sample_t    shift_nxt;

  assign half_end  = (cnt_q == cnt_w'(sclk_div - 1));
  assign gap_end   = (cnt_q == cnt_w'(acq_pkg::gap_cycles - 1));
  // sclk about to go high, so sdata is taken on this edge
  assign rise      = (state_q == acq_pkg::cap_shift) && half_end && !sclk_q;
  assign last_bit  = (bit_q == bit_w'(acq_pkg::sample_w - 1));
  assign shift_nxt = {shift_q[acq_pkg::sample_w-2:0], sdata};

  // --------------------
  // frame FSM
  // --------------------
  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= acq_pkg::cap_gap;
      cnt_q   <= '0;
      bit_q   <= '0;
      cs_n_q  <= 1'b1;
      sclk_q  <= 1'b0;
      vld_q   <= 1'b0;
    end else begin
      vld_q <= 1'b0;
      case (state_q)
        acq_pkg::cap_gap: begin
          if (gap_end) begin
            cnt_q   <= '0;
            bit_q   <= '0;
            cs_n_q  <= 1'b0;
            state_q <= acq_pkg::cap_shift;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        acq_pkg::cap_shift: begin
          if (half_end) begin
            cnt_q  <= '0;
            sclk_q <= ~sclk_q;
            if (rise) begin
              bit_q <= bit_q + 1'b1;
              // bit 0 lands here, frame closes
              if (last_bit) begin
                cs_n_q  <= 1'b1;
                vld_q   <= 1'b1;
                state_q <= acq_pkg::cap_done;
              end
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        acq_pkg::cap_done: begin
          // finish the high half of the last sclk pulse
          if (half_end) begin
            cnt_q   <= '0;
            sclk_q  <= 1'b0;
            state_q <= acq_pkg::cap_gap;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= acq_pkg::cap_gap;
      endcase
    end
  end

  // shift-in and sample hold
  always_ff @(posedge clk_sys) begin
    if (rise) begin
      shift_q <= shift_nxt;
      if (last_bit) begin
        data_q <= shift_nxt;
      end
    end
  end

  assign cs_n = cs_n_q;
  assign sclk = sclk_q;
  assign smp  = '{sample: data_q, vld: vld_q};

endmodule

// File: hdl/app_combine.sv
// combines the two smoothed channels into one record
// signed a minus b difference, alarm when its magnitude exceeds alarm_limit
module app_combine #(
  parameter acq_pkg::sample_t alarm_limit = 16'd1000
) (
  input  logic                clk_sys,
  input  logic                arst_n,
  input  acq_pkg::chan_data_t a,
  input  acq_pkg::chan_data_t b,
  output acq_pkg::result_t    res,
  output logic                res_vld
);

  acq_pkg::sample_t             hold_a_q;
  acq_pkg::sample_t             hold_b_q;
  logic                         pend_a_q;
  logic                         pend_b_q;
  logic                         pend_a;
  logic                         pend_b;
  logic                         both;
  acq_pkg::sample_t             cur_a;
  acq_pkg::sample_t             cur_b;
  acq_pkg::diff_t               diff_c;
  logic [acq_pkg::sample_w:0]   mag_c;
  logic                         alarm_c;
  acq_pkg::result_t             res_q;
  logic                         res_vld_q;

  // --------------------
  // pairing and compare
  // --------------------
  always_comb begin
    // a valid arriving now counts as pending
    pend_a  = pend_a_q | a.vld;
    pend_b  = pend_b_q | b.vld;
    both    = pend_a & pend_b;
    cur_a   = a.vld ? a.sample : hold_a_q;
    cur_b   = b.vld ? b.sample : hold_b_q;
    diff_c  = $signed({1'b0, cur_a}) - $signed({1'b0, cur_b});
    mag_c   = diff_c[acq_pkg::sample_w] ? $unsigned(-diff_c) : $unsigned(diff_c);
    alarm_c = (mag_c > {1'b0, alarm_limit});
  end

  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      pend_a_q  <= 1'b0;
      pend_b_q  <= 1'b0;
      res_vld_q <= 1'b0;
    end else begin
      res_vld_q <= both;
      if (both) begin
        pend_a_q <= 1'b0;
        pend_b_q <= 1'b0;
      end else begin
        pend_a_q <= pend_a;
        pend_b_q <= pend_b;
      end
    end
  end

  // latest sample per channel and the record
  always_ff @(posedge clk_sys) begin
    if (a.vld) begin
      hold_a_q <= a.sample;
    end
    if (b.vld) begin
      hold_b_q <= b.sample;
    end
    if (both) begin
      res_q <= '{ch_a: cur_a, ch_b: cur_b, diff: diff_c, alarm: alarm_c};
    end
  end

  assign res     = res_q;
  assign res_vld = res_vld_q;

endmodule

// File: hdl/dsp_smooth.sv
// boxcar smoothing for one channel
// averages the last 2^avg_log2 samples with a running sum
module dsp_smooth #(
  parameter int avg_log2 = 2
) (
  input  logic                clk_sys,
  input  logic                arst_n,
  input  acq_pkg::chan_data_t smp_in,
  output acq_pkg::chan_data_t smp_out
);

  localparam int depth = 2 ** avg_log2;
  // room for the sum of depth full-scale samples
  localparam int sum_w = acq_pkg::sample_w + avg_log2;

  acq_pkg::sample_t hist_q [depth];
  logic [sum_w-1:0] sum_q;
  logic [sum_w-1:0] sum_nxt;
  acq_pkg::sample_t avg_q;
  logic             vld_q;

  // new sample in, oldest of the window out
  assign sum_nxt = sum_q + sum_w'(smp_in.sample) - sum_w'(hist_q[depth-1]);

  // --------------------
  // window and running sum
  // --------------------
  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      sum_q <= '0;
      vld_q <= 1'b0;
      for (int i = 0; i < depth; i++) begin
        hist_q[i] <= '0;
      end
    end else begin
      vld_q <= smp_in.vld;
      if (smp_in.vld) begin
        sum_q     <= sum_nxt;
        hist_q[0] <= smp_in.sample;
        for (int i = 1; i < depth; i++) begin
          hist_q[i] <= hist_q[i-1];
        end
      end
    end
  end

  // divide by depth
  always_ff @(posedge clk_sys) begin
    if (smp_in.vld) begin
      avg_q <= sum_nxt[avg_log2 +: acq_pkg::sample_w];
    end
  end

  assign smp_out = '{sample: avg_q, vld: vld_q};

endmodule

// File: hdl/host_port.sv
// host read port with alarm interrupt
// keeps the latest record and serves it over a four-phase req/ack read
module host_port (
  input  logic             clk_sys,
  input  logic             arst_n,
  input  acq_pkg::result_t res,
  input  logic             res_vld,
  input  logic             rd_req,
  output logic             rd_ack,
  output acq_pkg::result_t rd_data,
  output logic             irq_n
);

  acq_pkg::rd_state_t rd_state_q;
  acq_pkg::result_t   latest_q;
  acq_pkg::result_t   rd_data_q;
  logic               alarm_pend_q;
  logic               alarm_new_q;
  logic               alarm_in;
  logic               rd_start;
  logic               rd_done;
  logic               rd_busy;

  assign alarm_in = res_vld & res.alarm;
  assign rd_start = (rd_state_q == acq_pkg::rd_idle) & rd_req;
  assign rd_done  = (rd_state_q == acq_pkg::rd_ack_hi) & ~rd_req;
  // results from here on miss the copy in rd_data
  assign rd_busy  = rd_start | (rd_state_q == acq_pkg::rd_ack_hi);

  // --------------------
  // handshake and irq
  // --------------------
  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      rd_state_q   <= acq_pkg::rd_idle;
      alarm_pend_q <= 1'b0;
      alarm_new_q  <= 1'b0;
    end else begin
      case (rd_state_q)
        acq_pkg::rd_idle:   if (rd_req) rd_state_q <= acq_pkg::rd_ack_hi;
        acq_pkg::rd_ack_hi: if (!rd_req) rd_state_q <= acq_pkg::rd_idle;
        default:            rd_state_q <= acq_pkg::rd_idle;
      endcase

      if (rd_done) begin
        // keep irq low only for an alarm the host has not seen
        alarm_pend_q <= alarm_new_q | alarm_in;
        alarm_new_q  <= 1'b0;
      end else begin
        if (alarm_in) begin
          alarm_pend_q <= 1'b1;
        end
        if (alarm_in && rd_busy) begin
          alarm_new_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_sys) begin
    if (res_vld) begin
      latest_q <= res;
    end
    // snapshot held for the whole read
    if (rd_start) begin
      rd_data_q <= latest_q;
    end
  end

  assign rd_ack  = (rd_state_q == acq_pkg::rd_ack_hi);
  assign rd_data = rd_data_q;
  assign irq_n   = ~alarm_pend_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# compile and run the acquisition front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Mdir "$obj_dir" \
  --top-module tb_acq_top -o tb_acq_top -f sim.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

"./$obj_dir/tb_acq_top" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$log"; then
  exit 1
fi
if ! grep -q "STATUS: PASS" "$log"; then
  echo "no result line found in $log"
  exit 1
fi
exit 0

// File: sim.f
hdl/acq_pkg.sv
hdl/ad_capture.sv
hdl/dsp_smooth.sv
hdl/app_combine.sv
hdl/host_port.sv
hdl/acq_top.sv
bench/adc_model.sv
bench/tb_acq_top.sv
